// ==== verilog/tlu_regs_pkg.sv ====
`default_nettype none

package tlu_regs_pkg;

    // one register byte on the config bus
    typedef logic [7:0] bus_byte_t;

    // register map, addresses in the low 5 bits of the bus address
    typedef enum logic [4:0] {
        ADDR_VERSION_RST    = 5'd0,  // read version, write soft reset
        ADDR_CONTROL        = 5'd1,
        ADDR_THRESHOLD      = 5'd2,
        ADDR_TRIGGER_SELECT = 5'd3,
        ADDR_VETO_SELECT    = 5'd4,
        ADDR_TRIGGER_INVERT = 5'd5,
        ADDR_COUNTER_0      = 5'd8,  // low byte, read latches the counter
        ADDR_COUNTER_1      = 5'd9,
        ADDR_COUNTER_2      = 5'd10,
        ADDR_COUNTER_3      = 5'd11, // write loads the counter
        ADDR_LOST_DATA      = 5'd12,
        ADDR_COUNTER_MAX_0  = 5'd16,
        ADDR_COUNTER_MAX_1  = 5'd17,
        ADDR_COUNTER_MAX_2  = 5'd18,
        ADDR_COUNTER_MAX_3  = 5'd19
    } reg_addr_e;

    localparam bus_byte_t TLU_VERSION = 8'd8;

    localparam int CONTROL_ENABLE_BIT = 0; // control register, trigger enable

endpackage

`default_nettype wire

// ==== verilog/trigger_pkg.sv ====
`default_nettype none

package trigger_pkg;

    // number of trigger and veto lines
    localparam int TRIGGER_INPUTS = 8;

    // flops on the asynchronous trigger and veto pins
    localparam int SYNC_STAGES = 2;

    // marker bit position in the data word
    localparam int TRIGGER_MARKER_BIT = 31;

    typedef logic [TRIGGER_INPUTS-1:0] trigger_mask_t; // select, invert or veto mask
    typedef logic [7:0] threshold_t;   // cycles a trigger must stay high
    typedef logic [31:0] trigger_count_t;

    // marker in bit 31, low 31 bits of the trigger number below
    typedef logic [31:0] trigger_word_t;

    typedef enum logic [2:0] {
        IDLE,
        QUALIFY,   // trigger held high, counting up to the threshold
        ACCEPT,    // single cycle, accepted flag high
        WAIT_ACK,
        WAIT_LOW   // wait for trigger release
    } trigger_state_e;

endpackage

`default_nettype wire

// ==== verilog/trigger_cfg_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// trigger configuration from the register bank to the trigger path
interface trigger_cfg_if
    import trigger_pkg::*;
();

    logic          enable;          // control register enable bit
    threshold_t    threshold;
    trigger_mask_t trigger_select;
    trigger_mask_t trigger_invert;
    trigger_mask_t veto_select;

    modport bank (
        output enable,
        output threshold,
        output trigger_select,
        output trigger_invert,
        output veto_select
    );

    modport input_side (
        input trigger_select,
        input trigger_invert,
        input veto_select
    );

    modport fsm_side (
        input enable,
        input threshold
    );

endinterface

`default_nettype wire

// ==== verilog/tlu_register_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module tlu_register_bank
    import tlu_regs_pkg::*;
    import trigger_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  logic [ADDR_WIDTH-1:0] bus_add,
    input  bus_byte_t             bus_data_in,
    input  logic                  bus_rd,
    input  logic                  bus_wr,
    output bus_byte_t             bus_data_out,
    output logic                  core_rst,
    input  logic                  trigger_accepted_flag,
    output trigger_count_t        trigger_count,
    output logic                  limit_reached,
    input  bus_byte_t             lost_data_count,
    trigger_cfg_if.bank           cfg
);

    logic           addr_valid; // upper address bits all zero
    reg_addr_e      addr;
    logic           wr_en;
    bus_byte_t      rd_mux;

    bus_byte_t      control_q;
    threshold_t     threshold_q;
    trigger_mask_t  trig_sel_q;
    trigger_mask_t  veto_sel_q;
    trigger_mask_t  trig_inv_q;
    bus_byte_t      cnt_load_q [3];  // bytes 0..2 of the counter load value
    bus_byte_t      cnt_max_q [4];
    trigger_count_t counter_max;
    trigger_count_t counter_q;
    trigger_count_t counter_latch_q; // upper bytes read from here
    logic           flag_d;

    assign addr_valid = ((bus_add >> 5) == '0);
    assign addr = reg_addr_e'(bus_add[4:0]);
    assign wr_en = bus_wr && addr_valid;

    // soft reset on RST or a write to address 0
    always_ff @(posedge BUS_CLK)
    begin
        core_rst <= RST | (wr_en && addr == ADDR_VERSION_RST);
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            control_q   <= '0;
            threshold_q <= '0;
            trig_sel_q  <= '0;
            veto_sel_q  <= '0;
            trig_inv_q  <= '0;
            for (int i = 0; i < 3; i++)
                cnt_load_q[i] <= '0;
            for (int i = 0; i < 4; i++)
                cnt_max_q[i] <= '0;
        end
        else if (wr_en)
        begin
            case (addr)
                ADDR_CONTROL:        control_q    <= bus_data_in;
                ADDR_THRESHOLD:      threshold_q  <= bus_data_in;
                ADDR_TRIGGER_SELECT: trig_sel_q   <= bus_data_in;
                ADDR_VETO_SELECT:    veto_sel_q   <= bus_data_in;
                ADDR_TRIGGER_INVERT: trig_inv_q   <= bus_data_in;
                ADDR_COUNTER_0:      cnt_load_q[0] <= bus_data_in;
                ADDR_COUNTER_1:      cnt_load_q[1] <= bus_data_in;
                ADDR_COUNTER_2:      cnt_load_q[2] <= bus_data_in;
                ADDR_COUNTER_MAX_0:  cnt_max_q[0] <= bus_data_in;
                ADDR_COUNTER_MAX_1:  cnt_max_q[1] <= bus_data_in;
                ADDR_COUNTER_MAX_2:  cnt_max_q[2] <= bus_data_in;
                ADDR_COUNTER_MAX_3:  cnt_max_q[3] <= bus_data_in;
                default: ;
            endcase
        end
    end

    assign counter_max = {cnt_max_q[3], cnt_max_q[2], cnt_max_q[1], cnt_max_q[0]};

    // increment one cycle after the flag, load has priority
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            counter_q     <= '0;
            flag_d        <= 1'b0;
            limit_reached <= 1'b0;
        end
        else
        begin
            flag_d <= trigger_accepted_flag;
            if (wr_en && addr == ADDR_COUNTER_3)
                counter_q <= {bus_data_in, cnt_load_q[2], cnt_load_q[1], cnt_load_q[0]};
            else if (flag_d)
                counter_q <= counter_q + 1'b1;
            limit_reached <= (counter_max != '0) && (counter_q >= counter_max);
        end
    end

    always_comb
    begin
        rd_mux = '0; // unmapped addresses read 0
        if (addr_valid)
        begin
            case (addr)
                ADDR_VERSION_RST:    rd_mux = TLU_VERSION;
                ADDR_CONTROL:        rd_mux = control_q;
                ADDR_THRESHOLD:      rd_mux = threshold_q;
                ADDR_TRIGGER_SELECT: rd_mux = trig_sel_q;
                ADDR_VETO_SELECT:    rd_mux = veto_sel_q;
                ADDR_TRIGGER_INVERT: rd_mux = trig_inv_q;
                ADDR_COUNTER_0:      rd_mux = counter_q[7:0];
                ADDR_COUNTER_1:      rd_mux = counter_latch_q[15:8];
                ADDR_COUNTER_2:      rd_mux = counter_latch_q[23:16];
                ADDR_COUNTER_3:      rd_mux = counter_latch_q[31:24];
                ADDR_LOST_DATA:      rd_mux = lost_data_count;
                ADDR_COUNTER_MAX_0:  rd_mux = cnt_max_q[0];
                ADDR_COUNTER_MAX_1:  rd_mux = cnt_max_q[1];
                ADDR_COUNTER_MAX_2:  rd_mux = cnt_max_q[2];
                ADDR_COUNTER_MAX_3:  rd_mux = cnt_max_q[3];
                default:             rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            bus_data_out    <= '0;
            counter_latch_q <= '0;
        end
        else if (bus_rd)
        begin
            bus_data_out <= rd_mux; // held until the next read
            if (addr_valid && addr == ADDR_COUNTER_0)
                counter_latch_q <= counter_q;
        end
    end

    assign trigger_count = counter_q;

    assign cfg.enable         = control_q[CONTROL_ENABLE_BIT];
    assign cfg.threshold      = threshold_q;
    assign cfg.trigger_select = trig_sel_q;
    assign cfg.trigger_invert = trig_inv_q;
    assign cfg.veto_select    = veto_sel_q;

endmodule

`default_nettype wire

// ==== verilog/trigger_input.sv ====
`timescale 1ns/100ps
`default_nettype none

module trigger_input
    import trigger_pkg::*;
(
    input  logic              BUS_CLK,
    input  logic              core_rst,
    input  trigger_mask_t     trigger,
    input  trigger_mask_t     trigger_veto,
    trigger_cfg_if.input_side cfg,
    output logic              trigger_level,
    output logic              veto_level
);

    // veto lines in the upper half, trigger lines in the lower half
    logic [SYNC_STAGES-1:0][2*TRIGGER_INPUTS-1:0] sync_q;

    trigger_mask_t trigger_sync;
    trigger_mask_t veto_sync;

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            sync_q <= '0;
        end
        else
        begin
            sync_q[0] <= {trigger_veto, trigger};
            for (int i = 1; i < SYNC_STAGES; i++)
                sync_q[i] <= sync_q[i-1];
        end
    end

    assign {veto_sync, trigger_sync} = sync_q[SYNC_STAGES-1];

    // invert first, then mask, then OR over all lines
    assign trigger_level = |((trigger_sync ^ cfg.trigger_invert) & cfg.trigger_select);

    assign veto_level = |(veto_sync & cfg.veto_select); // any selected veto blocks

endmodule

`default_nettype wire

// ==== verilog/trigger_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module trigger_fsm
    import trigger_pkg::*;
(
    input  logic            BUS_CLK,
    input  logic            core_rst,
    input  logic            trigger_level,
    input  logic            veto_level,
    input  logic            limit_reached,
    input  logic            ext_trigger_enable,
    input  logic            trigger_acknowledge,
    trigger_cfg_if.fsm_side cfg,
    output logic            trigger_accepted_flag
);

    trigger_state_e state_q;
    trigger_state_e state_d;
    threshold_t     qual_cnt_q;    // cycles the trigger has been seen high
    threshold_t     threshold_eff;
    logic           trigger_enabled;

    assign trigger_enabled = cfg.enable | ext_trigger_enable;

    // zero threshold acts like one
    assign threshold_eff = (cfg.threshold == '0) ? threshold_t'(1) : cfg.threshold;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (trigger_enabled && trigger_level && !veto_level && !limit_reached)
                    state_d = QUALIFY;
            QUALIFY:
                if (!trigger_level || veto_level)
                    state_d = IDLE; // pulse too short or vetoed
                else if (qual_cnt_q >= threshold_eff)
                    state_d = ACCEPT;
            ACCEPT:
                state_d = WAIT_ACK;
            WAIT_ACK:
                if (trigger_acknowledge)
                    state_d = WAIT_LOW;
            WAIT_LOW:
                if (!trigger_level)
                    state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            state_q    <= IDLE;
            qual_cnt_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            // the IDLE cycle that saw the trigger counts as the first one
            if (state_q != QUALIFY)
                qual_cnt_q <= threshold_t'(1);
            else if (qual_cnt_q < threshold_eff)
                qual_cnt_q <= qual_cnt_q + 1'b1;
        end
    end

    assign trigger_accepted_flag = (state_q == ACCEPT);

endmodule

`default_nettype wire

// ==== verilog/trigger_data_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module trigger_data_fifo
    import tlu_regs_pkg::*;
    import trigger_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic           BUS_CLK,
    input  logic           core_rst,
    input  logic           trigger_accepted_flag,
    input  trigger_count_t trigger_count,
    input  logic           fifo_read,
    output logic           fifo_empty,
    output trigger_word_t  fifo_data,
    output bus_byte_t      lost_data_count
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    trigger_word_t  mem [FIFO_DEPTH];
    logic [PTR_W:0] wr_ptr_q; // extra msb tells full from empty
    logic [PTR_W:0] rd_ptr_q;
    trigger_word_t  word_in;
    logic           fifo_full;

    assign word_in = {1'b1, trigger_count[TRIGGER_MARKER_BIT-1:0]};

    assign fifo_empty = (wr_ptr_q == rd_ptr_q);
    assign fifo_full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                        (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

    // show-ahead output
    assign fifo_data = mem[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge BUS_CLK)
    begin
        if (trigger_accepted_flag && !fifo_full)
            mem[wr_ptr_q[PTR_W-1:0]] <= word_in;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            wr_ptr_q        <= '0;
            rd_ptr_q        <= '0;
            lost_data_count <= '0;
        end
        else
        begin
            if (trigger_accepted_flag && !fifo_full)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            else if (trigger_accepted_flag && lost_data_count != 8'hff)
                lost_data_count <= lost_data_count + 1'b1; // saturates at 255
            if (fifo_read && !fifo_empty)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tlu_trigger_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tlu_trigger_core
    import tlu_regs_pkg::*;
    import trigger_pkg::*;
#(
    parameter int ADDR_WIDTH = 16,
    parameter int FIFO_DEPTH = 8  // power of two
)
(
    input  logic                  BUS_CLK,
    input  logic                  RST,

    input  logic [ADDR_WIDTH-1:0] bus_add,
    input  bus_byte_t             bus_data_in,
    input  logic                  bus_rd,
    input  logic                  bus_wr,
    output bus_byte_t             bus_data_out,

    input  logic                  fifo_read,
    output logic                  fifo_empty,
    output trigger_word_t         fifo_data,

    input  trigger_mask_t         trigger,
    input  trigger_mask_t         trigger_veto,
    input  logic                  ext_trigger_enable,
    input  logic                  trigger_acknowledge,
    output logic                  trigger_accepted_flag
);

    logic           core_rst;
    logic           trigger_level;
    logic           veto_level;
    logic           limit_reached;
    trigger_count_t trigger_count;
    bus_byte_t      lost_data_count;

    trigger_cfg_if cfg_if ();

    tlu_register_bank #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_register_bank (
        .BUS_CLK               (BUS_CLK),
        .RST                   (RST),
        .bus_add               (bus_add),
        .bus_data_in           (bus_data_in),
        .bus_rd                (bus_rd),
        .bus_wr                (bus_wr),
        .bus_data_out          (bus_data_out),
        .core_rst              (core_rst),
        .trigger_accepted_flag (trigger_accepted_flag),
        .trigger_count         (trigger_count),
        .limit_reached         (limit_reached),
        .lost_data_count       (lost_data_count),
        .cfg                   (cfg_if.bank)
    );

    trigger_input u_trigger_input (
        .BUS_CLK       (BUS_CLK),
        .core_rst      (core_rst),
        .trigger       (trigger),
        .trigger_veto  (trigger_veto),
        .cfg           (cfg_if.input_side),
        .trigger_level (trigger_level),
        .veto_level    (veto_level)
    );

    trigger_fsm u_trigger_fsm (
        .BUS_CLK               (BUS_CLK),
        .core_rst              (core_rst),
        .trigger_level         (trigger_level),
        .veto_level            (veto_level),
        .limit_reached         (limit_reached),
        .ext_trigger_enable    (ext_trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .cfg                   (cfg_if.fsm_side),
        .trigger_accepted_flag (trigger_accepted_flag)
    );

    // one word per accepted trigger, tagged with the pre-increment count
    trigger_data_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_data_fifo (
        .BUS_CLK               (BUS_CLK),
        .core_rst              (core_rst),
        .trigger_accepted_flag (trigger_accepted_flag),
        .trigger_count         (trigger_count),
        .fifo_read             (fifo_read),
        .fifo_empty            (fifo_empty),
        .fifo_data             (fifo_data),
        .lost_data_count       (lost_data_count)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_tlu_trigger.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_tlu_trigger
    import tlu_regs_pkg::*;
    import trigger_pkg::*;
();

    localparam int ADDR_WIDTH      = 16;
    localparam int FIFO_DEPTH      = 8;
    localparam int CLK_PERIOD      = 4;
    localparam int unsigned RAND_SEED = 32'ha303f8cd;
    localparam int N_COMB_GROUPS   = 3;
    localparam int N_COMB_PATTERNS = 8;
    localparam int N_THR_PULSES    = 30;
    localparam int N_CNT_TRIGGERS  = 6;

    // rough cycle cost of each test, summed for the watchdog
    localparam int BUDGET_CYCLES = 20 + 250
        + N_COMB_GROUPS * (40 + N_COMB_PATTERNS * 34)
        + N_THR_PULSES * 24 + 60 + 200
        + (N_CNT_TRIGGERS + FIFO_DEPTH + 9) * 22 + 400;
    localparam int WATCHDOG_NS = BUDGET_CYCLES * CLK_PERIOD + 400;

    logic                  BUS_CLK;
    logic                  RST;
    logic [ADDR_WIDTH-1:0] bus_add;
    bus_byte_t             bus_data_in;
    logic                  bus_rd;
    logic                  bus_wr;
    bus_byte_t             bus_data_out;
    logic                  fifo_read;
    logic                  fifo_empty;
    trigger_word_t         fifo_data;
    trigger_mask_t         trigger;
    trigger_mask_t         trigger_veto;
    logic                  ext_trigger_enable;
    logic                  trigger_acknowledge;
    logic                  trigger_accepted_flag;

    // reference model state
    bus_byte_t      reg_model [32];
    trigger_count_t model_count;
    trigger_count_t model_max;
    bus_byte_t      model_lost;
    trigger_word_t  word_q [$];

    int flag_cnt = 0;

    tlu_trigger_core #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .BUS_CLK               (BUS_CLK),
        .RST                   (RST),
        .bus_add               (bus_add),
        .bus_data_in           (bus_data_in),
        .bus_rd                (bus_rd),
        .bus_wr                (bus_wr),
        .bus_data_out          (bus_data_out),
        .fifo_read             (fifo_read),
        .fifo_empty            (fifo_empty),
        .fifo_data             (fifo_data),
        .trigger               (trigger),
        .trigger_veto          (trigger_veto),
        .ext_trigger_enable    (ext_trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .trigger_accepted_flag (trigger_accepted_flag)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    // flag is high for a whole cycle, so the falling edge sees it once
    always @(negedge BUS_CLK)
    begin
        if (trigger_accepted_flag)
            flag_cnt <= flag_cnt + 1;
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("watchdog timeout, the tests did not finish within their cycle budget");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_byte(input string name, input bus_byte_t exp_val, input bus_byte_t act);
        if (act !== exp_val)
            abort_run($sformatf("FAILED %s: expected 0x%02h, actual 0x%02h", name, exp_val, act));
    endtask

    task automatic check_word(input string name, input trigger_word_t exp_val,
                              input trigger_word_t act);
        if (act !== exp_val)
            abort_run($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp_val, act));
    endtask

    task automatic check_count(input string name, input trigger_count_t exp_val,
                               input trigger_count_t act);
        if (act !== exp_val)
            abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp_val, act));
    endtask

    // entered and left 1 ns after a rising edge
    task automatic step();
        @(posedge BUS_CLK);
        #1;
    endtask

    task automatic bus_write_raw(input logic [ADDR_WIDTH-1:0] a, input bus_byte_t d);
        bus_add     = a;
        bus_data_in = d;
        bus_wr      = 1'b1;
        step();
        bus_wr      = 1'b0;
    endtask

    task automatic bus_read_raw(input logic [ADDR_WIDTH-1:0] a, output bus_byte_t d);
        bus_add = a;
        bus_rd  = 1'b1;
        step();
        bus_rd  = 1'b0;
        d       = bus_data_out; // registered on the edge just passed
    endtask

    task automatic reg_write(input reg_addr_e a, input bus_byte_t d);
        bus_write_raw(ADDR_WIDTH'(a), d);
    endtask

    task automatic reg_read(input reg_addr_e a, output bus_byte_t d);
        bus_read_raw(ADDR_WIDTH'(a), d);
    endtask

    task automatic model_reset();
        for (int i = 0; i < 32; i++)
            reg_model[i] = 8'h00;
        reg_model[0] = TLU_VERSION;
        model_count  = '0;
        model_max    = '0;
        model_lost   = 8'h00;
        word_q.delete();
    endtask

    task automatic soft_reset();
        reg_write(ADDR_VERSION_RST, 8'h00);
        repeat (2) step();
        model_reset();
    endtask

    // disable, set masks with the inputs at rest, then enable
    task automatic configure(input trigger_mask_t sel, input trigger_mask_t inv,
                             input trigger_mask_t vsel, input bus_byte_t thr);
        reg_write(ADDR_CONTROL, 8'h00);
        trigger      = inv;
        trigger_veto = '0;
        reg_write(ADDR_TRIGGER_SELECT, sel);
        reg_write(ADDR_TRIGGER_INVERT, inv);
        reg_write(ADDR_VETO_SELECT, vsel);
        reg_write(ADDR_THRESHOLD, thr);
        repeat (4) step();
        reg_write(ADDR_CONTROL, bus_byte_t'(1 << CONTROL_ENABLE_BIT));
        repeat (2) step();
    endtask

    task automatic apply_pulse(input trigger_mask_t pat, input trigger_mask_t idle,
                               input int width, input int gap);
        trigger = pat;
        repeat (width) step();
        trigger = idle;
        repeat (gap) step();
    endtask

    task automatic load_counter(input trigger_count_t c);
        reg_write(ADDR_COUNTER_0, c[7:0]);
        reg_write(ADDR_COUNTER_1, c[15:8]);
        reg_write(ADDR_COUNTER_2, c[23:16]);
        reg_write(ADDR_COUNTER_3, c[31:24]); // loads all four bytes
        model_count = c;
    endtask

    task automatic write_counter_max(input trigger_count_t m);
        reg_write(ADDR_COUNTER_MAX_0, m[7:0]);
        reg_write(ADDR_COUNTER_MAX_1, m[15:8]);
        reg_write(ADDR_COUNTER_MAX_2, m[23:16]);
        reg_write(ADDR_COUNTER_MAX_3, m[31:24]);
        repeat (2) step();
        model_max = m;
    endtask

    task automatic read_counter(output trigger_count_t c);
        bus_byte_t b0;
        bus_byte_t b1;
        bus_byte_t b2;
        bus_byte_t b3;
        reg_read(ADDR_COUNTER_0, b0);
        reg_read(ADDR_COUNTER_1, b1);
        reg_read(ADDR_COUNTER_2, b2);
        reg_read(ADDR_COUNTER_3, b3);
        c = {b3, b2, b1, b0};
    endtask

    // a selected line fires when its level differs from its invert bit
    function automatic logic combined_trigger(input trigger_mask_t pat,
                                              input trigger_mask_t inv,
                                              input trigger_mask_t sel);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < TRIGGER_INPUTS; i++)
        begin
            if (sel[i] && (pat[i] != inv[i]))
                hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic logic vetoed(input trigger_mask_t vpat, input trigger_mask_t vsel);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < TRIGGER_INPUTS; i++)
        begin
            if (vsel[i] && vpat[i])
                hit = 1'b1;
        end
        return hit;
    endfunction

    // trigger decision, counter and FIFO of the model for one pulse
    task automatic model_accept(output logic accepted);
        accepted = !((model_max != '0) && (model_count >= model_max));
        if (accepted)
        begin
            if (word_q.size() < FIFO_DEPTH)
                word_q.push_back({1'b1, model_count[30:0]});
            else if (model_lost != 8'hff)
                model_lost = model_lost + 8'h01;
            model_count = model_count + 32'd1;
        end
    endtask

    task automatic drain_fifo(input string name);
        trigger_word_t exp_word;
        int            n;
        n = 0;
        while (word_q.size() > 0)
        begin
            if (fifo_empty)
                abort_run($sformatf("%s: FIFO is empty while %0d words are still expected",
                                    name, word_q.size()));
            exp_word = word_q.pop_front();
            check_word($sformatf("%s word %0d", name, n), exp_word, fifo_data);
            fifo_read = 1'b1;
            step();
            fifo_read = 1'b0;
            n++;
        end
        if (!fifo_empty)
            abort_run($sformatf("%s: FIFO holds more words than expected", name));
    endtask

    task automatic run_trigger(input string name);
        logic accepted;
        int   base;
        base = flag_cnt;
        model_accept(accepted);
        apply_pulse(trigger_mask_t'($urandom_range(1, 255)), '0, $urandom_range(2, 6), 10);
        check_count(name, trigger_count_t'(accepted ? 1 : 0), trigger_count_t'(flag_cnt - base));
    endtask

    initial
    begin
        int unsigned    seed_val;
        int             cfg_addrs [9];
        bus_byte_t      d;
        trigger_mask_t  sel;
        trigger_mask_t  inv;
        trigger_mask_t  vsel;
        trigger_mask_t  pat;
        trigger_mask_t  vpat;
        int             thr;
        int             thr_eff;
        int             w;
        int             k;
        int             extra;
        int             exp_flags;
        int             base;
        trigger_count_t cnt;

        RST                 = 1'b1;
        bus_add             = '0;
        bus_data_in         = '0;
        bus_rd              = 1'b0;
        bus_wr              = 1'b0;
        fifo_read           = 1'b0;
        trigger             = '0;
        trigger_veto        = '0;
        ext_trigger_enable  = 1'b0;
        trigger_acknowledge = 1'b0;
        seed_val            = $urandom(RAND_SEED);
        cfg_addrs           = '{1, 2, 3, 4, 5, 16, 17, 18, 19};
        model_reset();

        repeat (16) @(posedge BUS_CLK);
        #1;
        RST = 1'b0;
        repeat (3) step();

        if (trigger_accepted_flag !== 1'b0)
            abort_run("trigger_accepted_flag is high after reset");
        if (fifo_empty !== 1'b1)
            abort_run("fifo_empty is low after reset");
        check_byte("bus_data_out after reset", 8'h00, bus_data_out);

        // registers: defaults, random writes, unmapped reads, soft reset
        for (int a = 0; a < 32; a++)
        begin
            bus_read_raw(ADDR_WIDTH'(a), d);
            check_byte($sformatf("reset value addr %0d", a), reg_model[a], d);
        end
        foreach (cfg_addrs[i])
        begin
            d = bus_byte_t'($urandom);
            if (cfg_addrs[i] == 1)
                d[CONTROL_ENABLE_BIT] = 1'b0; // keep triggering off here
            reg_model[cfg_addrs[i]] = d;
            bus_write_raw(ADDR_WIDTH'(cfg_addrs[i]), d);
        end
        for (int a = 0; a < 32; a++)
        begin
            bus_read_raw(ADDR_WIDTH'(a), d);
            check_byte($sformatf("readback addr %0d", a), reg_model[a], d);
        end
        bus_read_raw(16'h0021, d);  // aliases addr 1 without the upper bits
        check_byte("unmapped addr 0x0021", 8'h00, d);
        bus_read_raw(16'h8005, d);
        check_byte("unmapped addr 0x8005", 8'h00, d);
        soft_reset();
        for (int a = 0; a < 32; a++)
        begin
            bus_read_raw(ADDR_WIDTH'(a), d);
            check_byte($sformatf("soft reset value addr %0d", a), reg_model[a], d);
        end

        // input combining with acknowledge held high
        trigger_acknowledge = 1'b1;
        for (int g = 0; g < N_COMB_GROUPS; g++)
        begin
            sel  = trigger_mask_t'($urandom);
            inv  = trigger_mask_t'($urandom);
            vsel = trigger_mask_t'($urandom);
            configure(sel, inv, vsel, bus_byte_t'($urandom_range(0, 3)));
            for (int p = 0; p < N_COMB_PATTERNS; p++)
            begin
                pat  = trigger_mask_t'($urandom);
                vpat = trigger_mask_t'($urandom & $urandom & $urandom); // sparse vetoes
                exp_flags = (combined_trigger(pat, inv, sel) && !vetoed(vpat, vsel)) ? 1 : 0;
                base = flag_cnt;
                trigger      = pat;
                trigger_veto = vpat;
                repeat (20) step();
                trigger      = inv;
                trigger_veto = '0;
                repeat (10) step();
                check_count($sformatf("combine group %0d pattern %0d", g, p),
                            trigger_count_t'(exp_flags), trigger_count_t'(flag_cnt - base));
            end
        end

        // threshold against pulse width
        soft_reset();
        thr     = $urandom_range(0, 6);
        thr_eff = (thr == 0) ? 1 : thr;
        configure(8'h01, 8'h00, 8'h00, bus_byte_t'(thr));
        for (int i = 0; i < N_THR_PULSES; i++)
        begin
            w = $urandom_range(1, 10);
            if (w == thr_eff)
                w = w + 1;
            exp_flags = (w >= thr_eff + 1) ? 1 : 0;
            base = flag_cnt;
            apply_pulse(8'h01, 8'h00, w, 8);
            check_count($sformatf("threshold %0d width %0d", thr, w),
                        trigger_count_t'(exp_flags), trigger_count_t'(flag_cnt - base));
        end

        // one trigger in flight until acknowledge
        soft_reset();
        trigger_acknowledge = 1'b0;
        configure(8'h01, 8'h00, 8'h00, 8'h01);
        base = flag_cnt;
        apply_pulse(8'h01, 8'h00, 4, 8);
        check_count("ack first trigger", 32'd1, trigger_count_t'(flag_cnt - base));
        apply_pulse(8'h01, 8'h00, 4, 8);
        check_count("ack second trigger blocked", 32'd1, trigger_count_t'(flag_cnt - base));
        trigger_acknowledge = 1'b1;
        repeat (4) step();
        trigger_acknowledge = 1'b0;
        repeat (2) step();
        apply_pulse(8'h01, 8'h00, 4, 8);
        check_count("ack trigger after release", 32'd2, trigger_count_t'(flag_cnt - base));
        trigger_acknowledge = 1'b1;

        // counter load, FIFO words, counter max, lost data
        soft_reset();
        if (fifo_empty !== 1'b1)
            abort_run("fifo_empty is low after soft reset with words in the FIFO");
        configure(8'hff, 8'h00, 8'h00, 8'h01);
        load_counter(trigger_count_t'($urandom & 32'h7fff_ffff));
        repeat (2) step();
        for (int i = 0; i < N_CNT_TRIGGERS; i++)
            run_trigger($sformatf("counted trigger %0d", i));
        drain_fifo("counted triggers");
        read_counter(cnt);
        check_count("counter after triggers", model_count, cnt);

        k = $urandom_range(1, 3);
        write_counter_max(model_count + trigger_count_t'(k));
        for (int i = 0; i < k + 2; i++)
            run_trigger($sformatf("counter max trigger %0d", i));
        write_counter_max('0);
        drain_fifo("counter max");
        read_counter(cnt);
        check_count("counter at max", model_count, cnt);

        extra = $urandom_range(1, 4);
        for (int i = 0; i < FIFO_DEPTH + extra; i++)
            run_trigger($sformatf("overflow trigger %0d", i));
        reg_read(ADDR_LOST_DATA, d);
        check_byte("lost data count", model_lost, d);
        drain_fifo("overflow");
        read_counter(cnt);
        check_count("counter after overflow", model_count, cnt);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/tlu_regs_pkg.sv
verilog/trigger_pkg.sv
verilog/trigger_cfg_if.sv
verilog/tlu_register_bank.sv
verilog/trigger_input.sv
verilog/trigger_fsm.sv
verilog/trigger_data_fifo.sv
verilog/tlu_trigger_core.sv
testbench/tb_tlu_trigger.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing
TOP      := tb_tlu_trigger
FILELIST := compile.f
OBJ_DIR  := obj_dir

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
